/* hw/io_settings.svh */
`ifndef IO_SETTINGS_SVH
`define IO_SETTINGS_SVH

// data bus port of the I/O segment.
`define IO_ADDR_W 16
`define IO_DATA_W 32

// region select field within the byte address.
`define IO_SEL_MSB 15
`define IO_SEL_LSB 12

`define SEG_DIGITS     6  // seven-segment displays on the board.
`define TIMER_CHANNELS 4  // compare channels, one interrupt line each.

`endif

/* hw/io_pkg.sv */
`default_nettype none

`include "io_settings.svh"

package io_pkg;

  // request from the bus master, held stable until ack or err.
  typedef struct packed {
    logic                      cyc;
    logic                      stb;
    logic                      we;
    logic [`IO_ADDR_W-1:0]     adr;
    logic [`IO_DATA_W/8-1:0]   sel;
    logic [`IO_DATA_W-1:0]     dat;
  } wb_req_t;

  typedef struct packed {
    logic                  ack;
    logic                  err;
    logic [`IO_DATA_W-1:0] dat;  // valid only while ack is high on a read.
  } wb_rsp_t;

  typedef enum logic [`IO_SEL_MSB-`IO_SEL_LSB:0] {
    REGION_SEG   = 4'd0,
    REGION_TIMER = 4'd8
  } io_region_e;

  // merges a write into a register word under the byte enables.
  function automatic logic [`IO_DATA_W-1:0] wb_merge(
    input logic [`IO_DATA_W-1:0]   old_v,
    input logic [`IO_DATA_W-1:0]   new_v,
    input logic [`IO_DATA_W/8-1:0] sel
  );
    logic [`IO_DATA_W-1:0] res;
    res = old_v;
    for (int b = 0; b < `IO_DATA_W / 8; b++) begin
      if (sel[b]) res[8*b +: 8] = new_v[8*b +: 8];
    end
    return res;
  endfunction

endpackage

`default_nettype wire

/* hw/io_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "io_settings.svh"

module io_decoder (
  input  wire logic            clk_i,
  input  wire logic            rst_i,
  input  wire io_pkg::wb_req_t m_req_i,
  output io_pkg::wb_rsp_t      m_rsp_o,
  output io_pkg::wb_req_t      seg_req_o,
  input  wire io_pkg::wb_rsp_t seg_rsp_i,
  output io_pkg::wb_req_t      tmr_req_o,
  input  wire io_pkg::wb_rsp_t tmr_rsp_i
);
  import io_pkg::*;

  io_region_e region;
  logic       unmapped;
  logic       err_q;

  assign region = io_region_e'(m_req_i.adr[`IO_SEL_MSB:`IO_SEL_LSB]);
  assign unmapped = (region != REGION_SEG) && (region != REGION_TIMER);

  // each peripheral sees the whole request, but only the addressed one gets stb.
  always_comb begin
    seg_req_o = m_req_i;
    tmr_req_o = m_req_i;
    seg_req_o.stb = m_req_i.stb && (region == REGION_SEG);
    tmr_req_o.stb = m_req_i.stb && (region == REGION_TIMER);
  end

  // registered so that an unmapped access keeps the same latency as a peripheral.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= m_req_i.cyc && m_req_i.stb && unmapped && !err_q;
    end
  end

  // the master holds the address until the reply, so the region still selects it.
  always_comb begin
    case (region)
      REGION_SEG: begin
        m_rsp_o = seg_rsp_i;
      end
      REGION_TIMER: begin
        m_rsp_o = tmr_rsp_i;
      end
      default: begin
        m_rsp_o.ack = 1'b0;
        m_rsp_o.err = err_q;
        m_rsp_o.dat = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* hw/seg_unit.sv */
`timescale 1ns/10ps
`default_nettype none

`include "io_settings.svh"

module seg_unit (
  input  wire logic                        clk_i,
  input  wire logic                        rst_i,
  input  wire io_pkg::wb_req_t             req_i,
  output io_pkg::wb_rsp_t                  rsp_o,
  input  wire logic [9:0]                  sw_i,
  output logic [`SEG_DIGITS-1:0][7:0]      hex_o
);
  import io_pkg::*;

  localparam int DIG_W  = 4 * `SEG_DIGITS;
  localparam int WORD_W = `IO_SEL_LSB - 2;

  localparam logic [WORD_W-1:0] W_DIGIT = WORD_W'(0);
  localparam logic [WORD_W-1:0] W_BLANK = WORD_W'(1);
  localparam logic [WORD_W-1:0] W_SW    = WORD_W'(2);

  logic [DIG_W-1:0]       dig_q;
  logic [`SEG_DIGITS-1:0] blank_q;
  logic [9:0]             sw_q;
  logic                   ack_q;
  logic [`IO_DATA_W-1:0]  rd_q;
  logic [`IO_DATA_W-1:0]  rd_d;
  logic [`IO_DATA_W-1:0]  dig_word;
  logic [`IO_DATA_W-1:0]  blank_word;
  logic [`IO_DATA_W-1:0]  wr_dig;
  logic [`IO_DATA_W-1:0]  wr_blank;
  logic [WORD_W-1:0]      word;
  logic                   hit;

  // segment pattern for a nibble, a in bit 0 through g in bit 6, active high.
  function automatic logic [6:0] seg_font(input logic [3:0] nib);
    case (nib)
      4'h0: return 7'h3f;
      4'h1: return 7'h06;
      4'h2: return 7'h5b;
      4'h3: return 7'h4f;
      4'h4: return 7'h66;
      4'h5: return 7'h6d;
      4'h6: return 7'h7d;
      4'h7: return 7'h07;
      4'h8: return 7'h7f;
      4'h9: return 7'h6f;
      4'ha: return 7'h77;
      4'hb: return 7'h7c;
      4'hc: return 7'h39;
      4'hd: return 7'h5e;
      4'he: return 7'h79;
      default: return 7'h71;
    endcase
  endfunction

  assign word = req_i.adr[`IO_SEL_LSB-1:2];
  assign hit = req_i.cyc && req_i.stb && !ack_q;  // one answer per request.

  assign dig_word = {{(`IO_DATA_W - DIG_W){1'b0}}, dig_q};
  assign blank_word = {{(`IO_DATA_W - `SEG_DIGITS){1'b0}}, blank_q};
  assign wr_dig = wb_merge(dig_word, req_i.dat, req_i.sel);
  assign wr_blank = wb_merge(blank_word, req_i.dat, req_i.sel);

  always_comb begin
    case (word)
      W_DIGIT: rd_d = dig_word;
      W_BLANK: rd_d = blank_word;
      W_SW:    rd_d = {{(`IO_DATA_W - 10){1'b0}}, sw_q};
      default: rd_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    sw_q <= sw_i;
    rd_q <= rd_d;
    if (rst_i) begin
      ack_q   <= 1'b0;
      dig_q   <= '0;
      blank_q <= '0;
    end else begin
      ack_q <= hit;
      if (hit && req_i.we) begin
        // unknown offsets and the switch word take the ack and nothing else.
        if (word == W_DIGIT) dig_q <= wr_dig[DIG_W-1:0];
        if (word == W_BLANK) blank_q <= wr_blank[`SEG_DIGITS-1:0];
      end
    end
  end

  assign rsp_o.ack = ack_q;
  assign rsp_o.err = 1'b0;
  assign rsp_o.dat = rd_q;

  // displays are active low and the decimal point stays dark.
  for (genvar i = 0; i < `SEG_DIGITS; i++) begin : g_digit
    assign hex_o[i] = blank_q[i] ? 8'hff : {1'b1, ~seg_font(dig_q[4*i +: 4])};
  end

endmodule

`default_nettype wire

/* hw/timer_unit.sv */
`timescale 1ns/10ps
`default_nettype none

`include "io_settings.svh"

module timer_unit (
  input  wire logic                       clk_i,
  input  wire logic                       rst_i,
  input  wire io_pkg::wb_req_t            req_i,
  output io_pkg::wb_rsp_t                 rsp_o,
  output logic [`TIMER_CHANNELS-1:0]      irq_o
);
  import io_pkg::*;

  localparam int WORD_W = `IO_SEL_LSB - 2;

  localparam logic [WORD_W-1:0] W_CTRL   = WORD_W'(0);
  localparam logic [WORD_W-1:0] W_COUNT  = WORD_W'(1);
  localparam logic [WORD_W-1:0] W_STATUS = WORD_W'(2);
  localparam logic [WORD_W-1:0] W_CMP    = WORD_W'(4);  // offset 0x10.

  logic                                          en_q;
  logic [`TIMER_CHANNELS-1:0]                    mask_q;
  logic [`IO_DATA_W-1:0]                         count_q;
  logic [`TIMER_CHANNELS-1:0]                    status_q;
  logic [`TIMER_CHANNELS-1:0][`IO_DATA_W-1:0]    cmp_q;
  logic [`TIMER_CHANNELS-1:0]                    irq_q;
  logic [`TIMER_CHANNELS-1:0]                    match;
  logic                                          ack_q;
  logic [`IO_DATA_W-1:0]                         rd_q;
  logic [`IO_DATA_W-1:0]                         rd_d;
  logic [`IO_DATA_W-1:0]                         ctrl_word;
  logic [`IO_DATA_W-1:0]                         wr_ctrl;
  logic [WORD_W-1:0]                             word;
  logic                                          hit;
  logic                                          wr;

  assign word = req_i.adr[`IO_SEL_LSB-1:2];
  assign hit = req_i.cyc && req_i.stb && !ack_q;
  assign wr = hit && req_i.we;

  assign ctrl_word = {{(`IO_DATA_W - 4 - `TIMER_CHANNELS){1'b0}}, mask_q, 3'b000, en_q};
  assign wr_ctrl = wb_merge(ctrl_word, req_i.dat, req_i.sel);

  // a channel only fires while the counter runs.
  always_comb begin
    for (int k = 0; k < `TIMER_CHANNELS; k++) begin
      match[k] = en_q && (count_q == cmp_q[k]);
    end
  end

  always_comb begin
    rd_d = '0;
    case (word)
      W_CTRL:   rd_d = ctrl_word;
      W_COUNT:  rd_d = count_q;
      W_STATUS: rd_d = {{(`IO_DATA_W - `TIMER_CHANNELS){1'b0}}, status_q};
      default: begin
        for (int k = 0; k < `TIMER_CHANNELS; k++) begin
          if (word == W_CMP + WORD_W'(k)) rd_d = cmp_q[k];
        end
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    rd_q <= rd_d;
    if (rst_i) begin
      ack_q    <= 1'b0;
      en_q     <= 1'b0;
      mask_q   <= '0;
      count_q  <= '0;
      status_q <= '0;
      cmp_q    <= '0;
      irq_q    <= '0;
    end else begin
      ack_q <= hit;
      irq_q <= status_q & mask_q;  // one cycle behind status.
      if (wr && word == W_COUNT) begin
        count_q <= wb_merge(count_q, req_i.dat, req_i.sel);
      end else if (en_q) begin
        count_q <= count_q + 1'b1;
      end
      if (wr && word == W_STATUS) begin
        status_q <= (status_q & ~req_i.dat[`TIMER_CHANNELS-1:0]) | match;  // a new hit wins.
      end else begin
        status_q <= status_q | match;
      end
      if (wr && word == W_CTRL) begin
        en_q   <= wr_ctrl[0];
        mask_q <= wr_ctrl[4 +: `TIMER_CHANNELS];
      end
      for (int k = 0; k < `TIMER_CHANNELS; k++) begin
        if (wr && word == W_CMP + WORD_W'(k)) cmp_q[k] <= wb_merge(cmp_q[k], req_i.dat, req_i.sel);
      end
    end
  end

  assign rsp_o.ack = ack_q;
  assign rsp_o.err = 1'b0;
  assign rsp_o.dat = rd_q;
  assign irq_o = irq_q;

endmodule

`default_nettype wire

/* hw/io_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "io_settings.svh"

module io_top (
  input  wire logic                      clk_i,
  input  wire logic                      rst_i,
  input  wire io_pkg::wb_req_t           wb_req_i,
  output io_pkg::wb_rsp_t                wb_rsp_o,
  input  wire logic [9:0]                sw_i,
  output logic [`SEG_DIGITS-1:0][7:0]    hex_o,
  output logic [`TIMER_CHANNELS-1:0]     timer_irq_o
);
  import io_pkg::*;

  wb_req_t seg_req;
  wb_rsp_t seg_rsp;
  wb_req_t tmr_req;
  wb_rsp_t tmr_rsp;

  io_decoder dec0 (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .m_req_i   (wb_req_i),
    .m_rsp_o   (wb_rsp_o),
    .seg_req_o (seg_req),
    .seg_rsp_i (seg_rsp),
    .tmr_req_o (tmr_req),
    .tmr_rsp_i (tmr_rsp)
  );

  seg_unit seg0 (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .req_i (seg_req),
    .rsp_o (seg_rsp),
    .sw_i  (sw_i),
    .hex_o (hex_o)
  );

  timer_unit timer0 (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .req_i (tmr_req),
    .rsp_o (tmr_rsp),
    .irq_o (timer_irq_o)
  );

endmodule

`default_nettype wire

/* bench/io_props.sv */
`timescale 1ns/10ps
`default_nettype none

`include "io_settings.svh"

module io_props (
  input wire logic                       clk_i,
  input wire logic                       rst_i,
  input wire io_pkg::wb_req_t            req_i,
  input wire io_pkg::wb_rsp_t            rsp_i,
  input wire logic [`TIMER_CHANNELS-1:0] irq_i
);
  import io_pkg::*;

  logic req_new;

  // a request that is not being answered yet.
  assign req_new = req_i.cyc && req_i.stb && !rsp_i.ack && !rsp_i.err;

  a_ack_err_excl: assert property (@(posedge clk_i) disable iff (rst_i)
    !(rsp_i.ack && rsp_i.err))
    else $error("ack and err are high in the same cycle");

  a_reply_latency: assert property (@(posedge clk_i) disable iff (rst_i)
    req_new |=> (rsp_i.ack || rsp_i.err))
    else $error("request was not answered one cycle after it was sampled");

  a_reply_single: assert property (@(posedge clk_i) disable iff (rst_i)
    (rsp_i.ack || rsp_i.err) |=> !(rsp_i.ack || rsp_i.err))
    else $error("reply lasted longer than one cycle");

  a_irq_reset: assert property (@(posedge clk_i)
    (rst_i && $past(rst_i)) |-> (irq_i == '0))
    else $error("timer interrupt high during reset");

endmodule

bind io_top io_props props0 (
  .clk_i (clk_i),
  .rst_i (rst_i),
  .req_i (wb_req_i),
  .rsp_i (wb_rsp_o),
  .irq_i (timer_irq_o)
);

`default_nettype wire

/* bench/io_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "io_settings.svh"

module io_tb;
  import io_pkg::*;

  localparam int ACK_TIMEOUT  = 16;
  localparam int POLL_TIMEOUT = 100;
  localparam logic [15:0] REG_ADRS [10] = '{16'h0000, 16'h0004, 16'h0008, 16'h8000, 16'h8004,
                                            16'h8008, 16'h8010, 16'h8014, 16'h8018, 16'h801c};

  logic                                clk;
  logic                                rst;
  wb_req_t                             req;
  wb_rsp_t                             rsp;
  logic [9:0]                          sw;
  logic [`SEG_DIGITS-1:0][7:0]         hex;
  logic [`TIMER_CHANNELS-1:0]          irq;

  integer      seed = 55;
  int          checks = 0;
  int          errors = 0;
  logic        bus_busy = 1'b1;
  logic        hex_watch = 1'b0;
  logic [23:0] m_dig = '0;  // register model of the writable registers.
  logic [5:0]  m_blank = '0;
  logic        m_en = 1'b0;
  logic [3:0]  m_mask = '0;
  logic [31:0] m_cmp [`TIMER_CHANNELS];

  io_top DUT (
    .clk_i       (clk),
    .rst_i       (rst),
    .wb_req_i    (req),
    .wb_rsp_o    (rsp),
    .sw_i        (sw),
    .hex_o       (hex),
    .timer_irq_o (irq)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // expected active low pattern of one display, decimal point dark.
  function automatic logic [7:0] seg_ref(input logic [3:0] nib, input logic blank);
    logic [7:0] pat;
    case (nib)
      4'h0: pat = 8'hc0;
      4'h1: pat = 8'hf9;
      4'h2: pat = 8'ha4;
      4'h3: pat = 8'hb0;
      4'h4: pat = 8'h99;
      4'h5: pat = 8'h92;
      4'h6: pat = 8'h82;
      4'h7: pat = 8'hf8;
      4'h8: pat = 8'h80;
      4'h9: pat = 8'h90;
      4'ha: pat = 8'h88;
      4'hb: pat = 8'h83;
      4'hc: pat = 8'hc6;
      4'hd: pat = 8'ha1;
      4'he: pat = 8'h86;
      default: pat = 8'h8e;
    endcase
    return blank ? 8'hff : pat;
  endfunction

  function automatic logic [31:0] apply_sel(input logic [31:0] old_v, input logic [31:0] new_v,
                                            input logic [3:0] sel);
    logic [31:0] m;
    m = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    return (old_v & ~m) | (new_v & m);
  endfunction

  function automatic logic [31:0] model_value(input logic [15:0] adr);
    case (adr)
      16'h0000: return {8'h00, m_dig};
      16'h0004: return {26'h0, m_blank};
      16'h8000: return {24'h0, m_mask, 3'b000, m_en};
      default:  return m_cmp[adr[3:2]];
    endcase
  endfunction

  task automatic model_write(input logic [15:0] adr, input logic [3:0] sel,
                             input logic [31:0] dat);
    logic [31:0] v;
    v = apply_sel(model_value(adr), dat, sel);
    case (adr)
      16'h0000: m_dig = v[23:0];
      16'h0004: m_blank = v[5:0];
      16'h8000: begin
        m_en = v[0];
        m_mask = v[7:4];
      end
      16'h8010, 16'h8014, 16'h8018, 16'h801c: m_cmp[adr[3:2]] = v;
      default: ;  // counter, status and read-only words hold no static model state.
    endcase
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic note_fail(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  // one classic cycle; the reply must come exactly one cycle after the request.
  task automatic bus_cycle(input logic we, input logic [15:0] adr, input logic [3:0] sel,
                           input logic [31:0] wdat, output logic [31:0] rdat,
                           output logic got_err);
    wb_req_t r;
    int      waited;
    logic    seen_ack;
    logic    seen_err;
    r = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, sel: sel, dat: wdat};
    @(posedge clk);
    bus_busy = 1'b1;
    req <= r;
    waited = 0;
    seen_ack = 1'b0;
    seen_err = 1'b0;
    rdat = '0;
    while (!seen_ack && !seen_err && waited < ACK_TIMEOUT) begin
      @(negedge clk);
      waited++;
      seen_ack = rsp.ack;
      seen_err = rsp.err;
    end
    if (seen_ack) rdat = rsp.dat;
    checks++;
    if (!seen_ack && !seen_err) begin
      note_fail($sformatf("no ack or err for address 0x%04h within %0d cycles", adr, waited));
    end else if (waited != 2) begin
      note_fail($sformatf("reply for address 0x%04h came after %0d cycles", adr, waited - 1));
    end
    got_err = seen_err;
    @(posedge clk);
    r.cyc = 1'b0;
    r.stb = 1'b0;
    req <= r;
    if (we && seen_ack) model_write(adr, sel, wdat);
    bus_busy = 1'b0;
  endtask

  task automatic bus_write(input logic [15:0] adr, input logic [3:0] sel, input logic [31:0] dat);
    logic [31:0] unused_rd;
    logic        e;
    bus_cycle(1'b1, adr, sel, dat, unused_rd, e);
    if (e) note_fail($sformatf("write to mapped address 0x%04h got err", adr));
  endtask

  task automatic bus_read(input logic [15:0] adr, output logic [31:0] dat);
    logic e;
    bus_cycle(1'b0, adr, 4'hf, 32'h0, dat, e);
    if (e) note_fail($sformatf("read of mapped address 0x%04h got err", adr));
  endtask

  task automatic check_lanes();
    @(negedge clk);
    for (int i = 0; i < `SEG_DIGITS; i++) begin
      check_val($sformatf("hex_o[%0d]", i), {24'h0, hex[i]},
                {24'h0, seg_ref(m_dig[4*i +: 4], m_blank[i])});
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (errors == errors_before) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, errors - errors_before);
  endtask

  // displays follow the model whenever no bus cycle is in flight.
  always @(negedge clk) begin
    if (hex_watch && !bus_busy) begin
      for (int i = 0; i < `SEG_DIGITS; i++) begin
        checks++;
        if (hex[i] !== seg_ref(m_dig[4*i +: 4], m_blank[i])) begin
          errors++;
          hex_watch = 1'b0;  // one report is enough for a stuck lane.
          $display("ERROR hex_o[%0d]: got 0x%02h, expected 0x%02h", i, hex[i],
                   seg_ref(m_dig[4*i +: 4], m_blank[i]));
        end
      end
    end
  end

  task automatic test_reset();
    int          e0;
    logic [31:0] d;
    e0 = errors;
    foreach (REG_ADRS[i]) begin
      bus_read(REG_ADRS[i], d);
      check_val($sformatf("register 0x%04h", REG_ADRS[i]), d, 32'h0);
    end
    check_lanes();
    report_test("reset state", e0);
  endtask

  task automatic test_digits();
    int          e0;
    logic [31:0] d;
    e0 = errors;
    repeat (8) begin
      bus_write(16'h0000, 4'hf, $random(seed));
      bus_read(16'h0000, d);
      check_val("digit register", d, {8'h00, m_dig});
      check_lanes();
    end
    report_test("digit decode", e0);
  endtask

  task automatic test_blank();
    int          e0;
    logic [31:0] d;
    e0 = errors;
    repeat (8) begin
      bus_write(16'h0004, 4'hf, $random(seed));
      check_lanes();
    end
    bus_write(16'h0004, 4'hf, 32'h0);
    bus_write(16'h0000, 4'hf, $random(seed));
    bus_write(16'h0000, 4'b0101, $random(seed));  // only bytes 0 and 2 may change.
    bus_read(16'h0000, d);
    check_val("digit register after partial write", d, {8'h00, m_dig});
    bus_write(16'h0000, 4'b0010, $random(seed));
    bus_read(16'h0000, d);
    check_val("digit register after partial write", d, {8'h00, m_dig});
    check_lanes();
    report_test("blank and byte enables", e0);
  endtask

  task automatic test_switches();
    int          e0;
    logic [9:0]  s;
    logic [31:0] d;
    e0 = errors;
    repeat (8) begin
      s = 10'($random(seed));
      @(posedge clk);
      sw <= s;
      bus_read(16'h0008, d);
      check_val("switch register", d, {22'h0, s});
    end
    report_test("switch readback", e0);
  endtask

  task automatic test_unmapped();
    int          e0;
    logic [31:0] d;
    logic        e;
    e0 = errors;
    bus_write(16'h0000, 4'hf, $random(seed));
    bus_write(16'h8010, 4'hf, $random(seed));
    bus_read(16'h0000, d);
    check_val("digit register before unmapped access", d, model_value(16'h0000));
    bus_cycle(1'b1, 16'h3000, 4'hf, $random(seed), d, e);
    check_val("err for region 3 write", {31'h0, e}, 32'h1);
    bus_cycle(1'b1, 16'hf004, 4'hf, 32'h3f, d, e);
    check_val("err for region 15 write", {31'h0, e}, 32'h1);
    bus_cycle(1'b0, 16'hf000, 4'hf, 32'h0, d, e);
    check_val("err for region 15 read", {31'h0, e}, 32'h1);
    foreach (REG_ADRS[i]) begin
      if (REG_ADRS[i] != 16'h0008 && REG_ADRS[i] != 16'h8004 && REG_ADRS[i] != 16'h8008) begin
        bus_read(REG_ADRS[i], d);
        check_val($sformatf("register 0x%04h", REG_ADRS[i]), d, model_value(REG_ADRS[i]));
      end
    end
    report_test("unmapped regions", e0);
  endtask

  task automatic test_timer();
    int          e0;
    int          polls;
    logic [31:0] c;
    logic [31:0] st;
    logic [31:0] cnt;
    e0 = errors;
    for (int k = 0; k < `TIMER_CHANNELS; k++) begin
      c = 32'd8 + ($random(seed) & 32'h1f);
      bus_write(16'h8004, 4'hf, 32'h0);
      bus_write(16'h8010 | 16'(k << 2), 4'hf, c);
      bus_write(16'h8008, 4'hf, 32'hf);
      bus_write(16'h8000, 4'hf, (32'h10 << k) | 32'h1);
      polls = 0;
      st = '0;
      while (!st[k] && polls < POLL_TIMEOUT) begin
        bus_read(16'h8008, st);
        polls++;
      end
      if (!st[k]) begin
        note_fail($sformatf("status bit %0d never set by its compare", k));
      end else begin
        bus_read(16'h8004, cnt);
        checks++;
        if (cnt < c) begin
          note_fail($sformatf("ERROR count: got 0x%08h, below compare 0x%08h", cnt, c));
        end
        @(negedge clk);
        check_val("timer_irq_o", {28'h0, irq}, {28'h0, (4'b0001 << k) & m_mask});
        bus_write(16'h8008, 4'hf, 32'h1 << k);  // write one to clear.
        polls = 0;
        @(negedge clk);
        while (irq[k] && polls < POLL_TIMEOUT) begin
          @(negedge clk);
          polls++;
        end
        checks++;
        if (irq[k]) note_fail($sformatf("timer_irq_o[%0d] stayed high after clear", k));
        bus_read(16'h8008, st);
        check_val($sformatf("status bit %0d after clear", k), {31'h0, st[k]}, 32'h0);
      end
      bus_write(16'h8000, 4'hf, 32'h0);
    end
    report_test("timer compare", e0);
  endtask

  initial begin
    rst = 1'b1;
    req = '0;
    sw = '0;
    for (int k = 0; k < `TIMER_CHANNELS; k++) m_cmp[k] = '0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    bus_busy = 1'b0;
    hex_watch = 1'b1;
    test_reset();
    test_digits();
    test_blank();
    test_switches();
    test_unmapped();
    test_timer();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+hw
hw/io_pkg.sv
hw/io_decoder.sv
hw/seg_unit.sv
hw/timer_unit.sv
hw/io_top.sv
bench/io_props.sv
bench/io_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f sources.f --top-module io_tb -Mdir obj_dir

status=0
./obj_dir/Vio_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test failures found" sim.log; then
  echo "simulation reported failures"
  exit 1
fi

echo "simulation finished without failures"
